// ==== verilog/core_pkg.sv ====
package core_pkg;

    // datapath and instruction widths
    localparam int xlen       = 64;
    localparam int inst_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 12;
    localparam int op_w       = 5;

    // field positions inside the instruction word, imm sits at bit 0
    localparam int op_lsb = 27;
    localparam int rd_lsb = 22;
    localparam int rs_lsb = 17;
    localparam int rt_lsb = 12;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 64'h2000;

    typedef enum logic [op_w-1:0] {
        // logic, 0x00 doubles as the zeroed bubble
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        // shifts
        op_shr    = 5'h04,
        op_shri   = 5'h05,
        op_shl    = 5'h06,
        op_shli   = 5'h07,
        // control flow
        op_jmp    = 5'h08,
        op_jmp_rr = 5'h09,
        op_jmp_ri = 5'h0A,
        op_brnz   = 5'h0B,
        op_brgt   = 5'h0E,
        op_halt   = 5'h0F,
        // data movement
        op_load   = 5'h10,
        op_mov    = 5'h11,
        op_mov_l  = 5'h12,
        op_store  = 5'h13,
        // arithmetic
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1A,
        op_subi   = 5'h1B
    } opcode_t;

    // run/halt sequencing of the front end
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain,
        st_halted
    } ctrl_state_t;

endpackage

// ==== verilog/alu.sv ====
module alu (
    input  core_pkg::opcode_t         op,
    input  logic [core_pkg::xlen-1:0] pc,
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    input  logic [core_pkg::xlen-1:0] rd_val,
    output logic [core_pkg::xlen-1:0] result,
    output logic                      reg_we,
    output logic                      mem_we,
    output logic [core_pkg::xlen-1:0] addr,
    output logic [core_pkg::xlen-1:0] wdata,
    output logic                      take,
    output logic [core_pkg::xlen-1:0] target
);

    always_comb begin
        result = '0;
        reg_we = 1'b0;
        mem_we = 1'b0;
        // load address, rs + L
        addr   = a + b;
        wdata  = a;
        take   = 1'b0;
        target = rd_val;
        case (op)
            core_pkg::op_add, core_pkg::op_addi: begin
                result = a + b;
                reg_we = 1'b1;
            end
            core_pkg::op_sub, core_pkg::op_subi: begin
                result = a - b;
                reg_we = 1'b1;
            end
            core_pkg::op_and: {reg_we, result} = {1'b1, a & b};
            core_pkg::op_or:  {reg_we, result} = {1'b1, a | b};
            core_pkg::op_xor: {reg_we, result} = {1'b1, a ^ b};
            core_pkg::op_not: {reg_we, result} = {1'b1, ~a};
            // full-width shift amount, 64 and up gives zero
            core_pkg::op_shr, core_pkg::op_shri: {reg_we, result} = {1'b1, a >> b};
            core_pkg::op_shl, core_pkg::op_shli: {reg_we, result} = {1'b1, a << b};
            core_pkg::op_mov: {reg_we, result} = {1'b1, a};
            // only the low 12 bits of rd change
            core_pkg::op_mov_l: begin
                result = {rd_val[core_pkg::xlen-1:core_pkg::imm_w], b[core_pkg::imm_w-1:0]};
                reg_we = 1'b1;
            end
            // data itself is picked up in MEM
            core_pkg::op_load: reg_we = 1'b1;
            core_pkg::op_store: begin
                mem_we = 1'b1;
                addr   = rd_val + b;
            end
            core_pkg::op_jmp:    take = 1'b1;
            core_pkg::op_jmp_rr: {take, target} = {1'b1, pc + rd_val};
            core_pkg::op_jmp_ri: {take, target} = {1'b1, pc + b};
            core_pkg::op_brnz:   take = a != '0;
            core_pkg::op_brgt:   take = $signed(a) > $signed(b);
            // halt only travels down the pipe
            default: ;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::reg_addr_w-1:0] rs,
    input  logic [core_pkg::reg_addr_w-1:0] rt,
    input  logic [core_pkg::reg_addr_w-1:0] rd_idx,
    input  logic [core_pkg::reg_addr_w-1:0] dbg_reg_addr,
    input  logic                            wb_we,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [core_pkg::xlen-1:0]       wb_data,
    output logic [core_pkg::xlen-1:0]       rs_val,
    output logic [core_pkg::xlen-1:0]       rt_val,
    output logic [core_pkg::xlen-1:0]       rd_val,
    output logic [core_pkg::xlen-1:0]       dbg_reg_data
);

    logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_addr_w];

    // r0 is a plain register here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle writeback shows up on every read port
    function automatic logic [core_pkg::xlen-1:0] rd_port(
        input logic [core_pkg::reg_addr_w-1:0] idx
    );
        return (wb_we && wb_rd == idx) ? wb_data : regs[idx];
    endfunction

    always_comb begin
        rs_val       = rd_port(rs);
        rt_val       = rd_port(rt);
        rd_val       = rd_port(rd_idx);
        dbg_reg_data = rd_port(dbg_reg_addr);
    end

endmodule

// ==== verilog/pipe_control.sv ====
module pipe_control #(
    parameter logic [core_pkg::xlen-1:0] start_pc = core_pkg::reset_pc
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  logic [core_pkg::inst_w-1:0]     inst,
    input  logic                            ex_load,
    input  logic [core_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                            em_take,
    input  logic [core_pkg::xlen-1:0]       em_target,
    input  logic                            wb_halt,
    output logic [core_pkg::xlen-1:0]       fetch_pc,
    output logic [core_pkg::reg_addr_w-1:0] rs,
    output logic [core_pkg::reg_addr_w-1:0] rt,
    output logic [core_pkg::reg_addr_w-1:0] rd_idx,
    output logic                            dec_valid,
    output core_pkg::opcode_t               dec_op,
    output logic [core_pkg::reg_addr_w-1:0] dec_rd,
    output logic [core_pkg::reg_addr_w-1:0] dec_rs,
    output logic [core_pkg::reg_addr_w-1:0] dec_rt,
    output logic [core_pkg::imm_w-1:0]      dec_imm,
    output logic [core_pkg::xlen-1:0]       dec_pc,
    output logic                            uses_rt,
    output logic                            flush,
    output logic                            hlt
);

    core_pkg::ctrl_state_t       state;
    logic [core_pkg::inst_w-1:0] ir;
    logic                        ir_valid;
    logic                        stall;
    logic                        go;
    logic                        halt_fire;

    // field slicing of the IF/ID word
    assign dec_op  = core_pkg::opcode_t'(ir[core_pkg::op_lsb +: core_pkg::op_w]);
    assign rd_idx  = ir[core_pkg::rd_lsb +: core_pkg::reg_addr_w];
    assign rs      = ir[core_pkg::rs_lsb +: core_pkg::reg_addr_w];
    assign rt      = ir[core_pkg::rt_lsb +: core_pkg::reg_addr_w];
    assign dec_imm = ir[core_pkg::imm_w-1:0];
    assign dec_rd  = rd_idx;
    assign dec_rs  = rs;
    assign dec_rt  = rt;

    // immediate and memory forms put L where rt would be
    always_comb begin
        case (dec_op)
            core_pkg::op_addi, core_pkg::op_subi, core_pkg::op_shri, core_pkg::op_shli,
            core_pkg::op_mov_l, core_pkg::op_jmp_ri, core_pkg::op_load,
            core_pkg::op_store: uses_rt = 1'b0;
            default:            uses_rt = 1'b1;
        endcase
    end

    // load in EX feeding decode
    // rd compared always, covers store, mov_l and the rd-based branches
    assign stall = ir_valid && ex_load &&
                   (ex_rd == rs || (uses_rt && ex_rd == rt) || ex_rd == rd_idx);

    // taken branch already sitting in EX/MEM
    assign flush     = em_take;
    // a stalled word leaves a bubble behind it
    assign dec_valid = ir_valid && !stall;
    assign halt_fire = dec_valid && !flush && dec_op == core_pkg::op_halt;
    // first edge with run high already fetches
    assign go        = state == core_pkg::st_run || (state == core_pkg::st_idle && run);
    assign hlt       = state == core_pkg::st_halted;

    // PC and IF/ID valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_pc <= start_pc;
            ir_valid <= 1'b0;
        end else if (flush) begin
            fetch_pc <= em_target;
            ir_valid <= 1'b0;
        end else if (!stall) begin
            if (go && !halt_fire) begin
                fetch_pc <= fetch_pc + 'd4;
            end
            // nothing behind a halt enters decode
            ir_valid <= go && !halt_fire;
        end
    end

    // IF/ID payload held through a stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ir     <= inst;
            dec_pc <= fetch_pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= core_pkg::st_idle;
        end else begin
            case (state)
                core_pkg::st_idle: if (run) state <= core_pkg::st_run;
                core_pkg::st_run:  if (halt_fire) state <= core_pkg::st_drain;
                core_pkg::st_drain: begin
                    // an older taken branch kills the halt, so fetch resumes
                    if (flush) begin
                        state <= core_pkg::st_run;
                    end else if (wb_halt) begin
                        state <= core_pkg::st_halted;
                    end
                end
                default: state <= core_pkg::st_halted;
            endcase
        end
    end

    // sticky halt until the next reset
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt);

endmodule

// ==== verilog/execute_stage.sv ====
module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            dec_valid,
    input  core_pkg::opcode_t               dec_op,
    input  logic [core_pkg::reg_addr_w-1:0] dec_rd,
    input  logic [core_pkg::reg_addr_w-1:0] dec_rs,
    input  logic [core_pkg::reg_addr_w-1:0] dec_rt,
    input  logic [core_pkg::imm_w-1:0]      dec_imm,
    input  logic [core_pkg::xlen-1:0]       dec_pc,
    input  logic                            uses_rt,
    input  logic [core_pkg::xlen-1:0]       rs_val,
    input  logic [core_pkg::xlen-1:0]       rt_val,
    input  logic [core_pkg::xlen-1:0]       rd_val,
    input  logic                            wb_we,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [core_pkg::xlen-1:0]       wb_data,
    output logic                            em_valid,
    output core_pkg::opcode_t               em_op,
    output logic [core_pkg::reg_addr_w-1:0] em_rd,
    output logic [core_pkg::xlen-1:0]       em_result,
    output logic                            em_reg_we,
    output logic                            em_mem_we,
    output logic [core_pkg::xlen-1:0]       em_addr,
    output logic [core_pkg::xlen-1:0]       em_wdata,
    output logic                            em_take,
    output logic [core_pkg::xlen-1:0]       em_target,
    output logic                            ex_load,
    output logic [core_pkg::reg_addr_w-1:0] ex_rd
);

    // ID/EX
    logic                            id_valid;
    core_pkg::opcode_t               id_op;
    logic [core_pkg::reg_addr_w-1:0] id_rd;
    logic [core_pkg::reg_addr_w-1:0] id_rs;
    logic [core_pkg::reg_addr_w-1:0] id_rt;
    logic [core_pkg::imm_w-1:0]      id_imm;
    logic [core_pkg::xlen-1:0]       id_pc;
    logic                            id_uses_rt;
    logic [core_pkg::xlen-1:0]       id_rs_val;
    logic [core_pkg::xlen-1:0]       id_rt_val;
    logic [core_pkg::xlen-1:0]       id_rd_val;

    // operands after forwarding
    logic [core_pkg::xlen-1:0]       fwd_rs;
    logic [core_pkg::xlen-1:0]       fwd_rt;
    logic [core_pkg::xlen-1:0]       fwd_rd;
    logic [core_pkg::xlen-1:0]       alu_a;
    logic [core_pkg::xlen-1:0]       alu_b;

    logic [core_pkg::xlen-1:0]       alu_result;
    logic                            alu_reg_we;
    logic                            alu_mem_we;
    logic [core_pkg::xlen-1:0]       alu_addr;
    logic [core_pkg::xlen-1:0]       alu_wdata;
    logic                            alu_take;
    logic [core_pkg::xlen-1:0]       alu_target;
    logic                            ex_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= dec_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        id_op      <= dec_op;
        id_rd      <= dec_rd;
        id_rs      <= dec_rs;
        id_rt      <= dec_rt;
        id_imm     <= dec_imm;
        id_pc      <= dec_pc;
        id_uses_rt <= uses_rt;
        id_rs_val  <= rs_val;
        id_rt_val  <= rt_val;
        id_rd_val  <= rd_val;
    end

    // youngest producer wins
    // a load in EX/MEM has no data yet, the stall keeps it from mattering
    function automatic logic [core_pkg::xlen-1:0] fwd(
        input logic [core_pkg::reg_addr_w-1:0] idx,
        input logic [core_pkg::xlen-1:0]       reg_val
    );
        if (em_reg_we && em_op != core_pkg::op_load && em_rd == idx) begin
            return em_result;
        end else if (wb_we && wb_rd == idx) begin
            return wb_data;
        end else begin
            return reg_val;
        end
    endfunction

    always_comb begin
        fwd_rs = fwd(id_rs, id_rs_val);
        fwd_rt = fwd(id_rt, id_rt_val);
        fwd_rd = fwd(id_rd, id_rd_val);
        // addi and subi accumulate into rd
        if (id_op == core_pkg::op_addi || id_op == core_pkg::op_subi) begin
            alu_a = fwd_rd;
        end else begin
            alu_a = fwd_rs;
        end
        // sign-extended L for the immediate forms
        if (id_uses_rt) begin
            alu_b = fwd_rt;
        end else begin
            alu_b = {{(core_pkg::xlen-core_pkg::imm_w){id_imm[core_pkg::imm_w-1]}}, id_imm};
        end
    end

    alu u_alu (
        .op     (id_op),
        .pc     (id_pc),
        .a      (alu_a),
        .b      (alu_b),
        .rd_val (fwd_rd),
        .result (alu_result),
        .reg_we (alu_reg_we),
        .mem_we (alu_mem_we),
        .addr   (alu_addr),
        .wdata  (alu_wdata),
        .take   (alu_take),
        .target (alu_target)
    );

    // the instruction in EX is younger than a taken branch in EX/MEM
    assign ex_valid = id_valid && !flush;
    assign ex_load  = id_valid && id_op == core_pkg::op_load;
    assign ex_rd    = id_rd;

    // EX/MEM strobes carry the valid bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            em_valid  <= 1'b0;
            em_reg_we <= 1'b0;
            em_mem_we <= 1'b0;
            em_take   <= 1'b0;
        end else begin
            em_valid  <= ex_valid;
            em_reg_we <= ex_valid && alu_reg_we;
            em_mem_we <= ex_valid && alu_mem_we;
            em_take   <= ex_valid && alu_take;
        end
    end

    always_ff @(posedge clk) begin
        em_op     <= id_op;
        em_rd     <= id_rd;
        em_result <= alu_result;
        em_addr   <= alu_addr;
        em_wdata  <= alu_wdata;
        em_target <= alu_target;
    end

    // decode passes raw opcode bits, an undefined code has no enum name
    op_known: assert property (@(posedge clk) disable iff (reset)
        id_valid |-> id_op.name() != "");

endmodule

// ==== verilog/core_memory.sv ====
module core_memory #(
    parameter int mem_bytes = 16384
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            load_en,
    input  logic [core_pkg::xlen-1:0]       load_addr,
    input  logic [core_pkg::inst_w-1:0]     load_word,
    input  logic [core_pkg::xlen-1:0]       fetch_pc,
    input  logic                            em_valid,
    input  core_pkg::opcode_t               em_op,
    input  logic [core_pkg::reg_addr_w-1:0] em_rd,
    input  logic [core_pkg::xlen-1:0]       em_result,
    input  logic                            em_reg_we,
    input  logic                            em_mem_we,
    input  logic [core_pkg::xlen-1:0]       em_addr,
    input  logic [core_pkg::xlen-1:0]       em_wdata,
    output logic [core_pkg::inst_w-1:0]     inst,
    output logic                            wb_we,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic [core_pkg::xlen-1:0]       wb_data,
    output logic                            wb_halt
);

    // power-of-two size, addresses wrap
    localparam int aw = $clog2(mem_bytes);

    logic [7:0]                mem [mem_bytes];
    logic [core_pkg::xlen-1:0] load_data;

    // little-endian reads, fetch and MEM-stage load
    always_comb begin
        for (int k = 0; k < core_pkg::inst_w / 8; k++) begin
            inst[8*k +: 8] = mem[fetch_pc[aw-1:0] + aw'(k)];
        end
        for (int k = 0; k < core_pkg::xlen / 8; k++) begin
            load_data[8*k +: 8] = mem[em_addr[aw-1:0] + aw'(k)];
        end
    end

    // program load while idle, stores once running
    always_ff @(posedge clk) begin
        if (load_en) begin
            for (int k = 0; k < core_pkg::inst_w / 8; k++) begin
                mem[load_addr[aw-1:0] + aw'(k)] <= load_word[8*k +: 8];
            end
        end
        if (em_mem_we) begin
            for (int k = 0; k < core_pkg::xlen / 8; k++) begin
                mem[em_addr[aw-1:0] + aw'(k)] <= em_wdata[8*k +: 8];
            end
        end
    end

    // MEM/WB
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we   <= 1'b0;
            wb_halt <= 1'b0;
        end else begin
            wb_we   <= em_reg_we;
            wb_halt <= em_valid && em_op == core_pkg::op_halt;
        end
    end

    // writeback select, load data or ALU result
    always_ff @(posedge clk) begin
        wb_rd   <= em_rd;
        wb_data <= (em_op == core_pkg::op_load) ? load_data : em_result;
    end

    // the loader and a running store never share the write port
    load_vs_store: assert property (@(posedge clk) disable iff (reset)
        !(load_en && em_mem_we));

endmodule

// ==== verilog/core_top.sv ====
module core_top #(
    parameter int                          mem_bytes = 16384,
    parameter logic [core_pkg::xlen-1:0]   start_pc  = core_pkg::reset_pc
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [core_pkg::xlen-1:0]       load_addr,
    input  logic [core_pkg::inst_w-1:0]     load_word,
    input  logic [core_pkg::reg_addr_w-1:0] dbg_reg_addr,
    output logic [core_pkg::xlen-1:0]       dbg_reg_data,
    output logic                            hlt
);

    // fetch path
    logic [core_pkg::xlen-1:0]       fetch_pc;
    logic [core_pkg::inst_w-1:0]     inst;

    // decode packet and register reads
    logic [core_pkg::reg_addr_w-1:0] rs;
    logic [core_pkg::reg_addr_w-1:0] rt;
    logic [core_pkg::reg_addr_w-1:0] rd_idx;
    logic                            dec_valid;
    core_pkg::opcode_t               dec_op;
    logic [core_pkg::reg_addr_w-1:0] dec_rd;
    logic [core_pkg::reg_addr_w-1:0] dec_rs;
    logic [core_pkg::reg_addr_w-1:0] dec_rt;
    logic [core_pkg::imm_w-1:0]      dec_imm;
    logic [core_pkg::xlen-1:0]       dec_pc;
    logic                            uses_rt;
    logic                            flush;
    logic [core_pkg::xlen-1:0]       rs_val;
    logic [core_pkg::xlen-1:0]       rt_val;
    logic [core_pkg::xlen-1:0]       rd_val;

    // load-use check back to decode
    logic                            ex_load;
    logic [core_pkg::reg_addr_w-1:0] ex_rd;

    // EX/MEM stage
    logic                            em_valid;
    core_pkg::opcode_t               em_op;
    logic [core_pkg::reg_addr_w-1:0] em_rd;
    logic [core_pkg::xlen-1:0]       em_result;
    logic                            em_reg_we;
    logic                            em_mem_we;
    logic [core_pkg::xlen-1:0]       em_addr;
    logic [core_pkg::xlen-1:0]       em_wdata;
    logic                            em_take;
    logic [core_pkg::xlen-1:0]       em_target;

    // MEM/WB stage, also the forwarding source
    logic                            wb_we;
    logic [core_pkg::reg_addr_w-1:0] wb_rd;
    logic [core_pkg::xlen-1:0]       wb_data;
    logic                            wb_halt;

    // all names line up with the submodule ports
    pipe_control #(.start_pc(start_pc)) u_pipe_control (.*);

    reg_file u_reg_file (.*);

    execute_stage u_execute_stage (.*);

    core_memory #(.mem_bytes(mem_bytes)) u_core_memory (.*);

endmodule

// ==== dv/core_tb_programs.svh ====
`ifndef core_tb_programs_svh
`define core_tb_programs_svh

// one row per test, its words sit in prog_words from first_word on
localparam int max_tests = 8;

string       test_name  [max_tests];
int          first_word [max_tests];
int          word_count [max_tests];
logic [4:0]  result_reg [max_tests];
logic [63:0] expected   [max_tests];
logic [31:0] prog_words [$];
int          num_tests;

// op rd rs rt L
task automatic emit(input core_pkg::opcode_t op, input logic [4:0] rd, input logic [4:0] rs,
                    input logic [4:0] rt, input logic [11:0] l);
    prog_words.push_back({op, rd, rs, rt, l});
endtask

task automatic start_entry(input string name);
    test_name[num_tests]  = name;
    first_word[num_tests] = prog_words.size();
endtask

task automatic finish_entry(input logic [4:0] rreg, input logic [63:0] value);
    word_count[num_tests] = prog_words.size() - first_word[num_tests];
    result_reg[num_tests] = rreg;
    expected[num_tests]   = value;
    num_tests++;
endtask

// dependent chain, each op reads the one before it
task automatic alu_entry(input string name);
    logic [11:0] a;
    logic [11:0] b;
    logic [11:0] c;
    logic [11:0] c2;
    logic [4:0]  s1;
    logic [5:0]  s2;
    logic [63:0] v3;
    logic [63:0] v4;
    logic [63:0] v6;
    a  = 12'(rand_bits(12));
    b  = 12'(rand_bits(12));
    c  = 12'(rand_bits(12));
    c2 = 12'(rand_bits(12));
    s1 = 5'(rand_bits(5));
    s2 = 6'(rand_bits(6));
    start_entry(name);
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, a);
    emit(core_pkg::op_mov_l, 5'd2, 5'd0, 5'd0, b);
    emit(core_pkg::op_mov_l, 5'd9, 5'd0, 5'd0, 12'(s2));
    emit(core_pkg::op_add, 5'd3, 5'd1, 5'd2, 12'h000);
    emit(core_pkg::op_sub, 5'd4, 5'd3, 5'd1, 12'h000);
    emit(core_pkg::op_subi, 5'd4, 5'd0, 5'd0, c);
    emit(core_pkg::op_xor, 5'd5, 5'd4, 5'd3, 12'h000);
    emit(core_pkg::op_not, 5'd6, 5'd5, 5'd0, 12'h000);
    emit(core_pkg::op_shli, 5'd7, 5'd6, 5'd0, 12'(s1));
    emit(core_pkg::op_shr, 5'd8, 5'd7, 5'd9, 12'h000);
    emit(core_pkg::op_or, 5'd8, 5'd8, 5'd1, 12'h000);
    emit(core_pkg::op_addi, 5'd8, 5'd0, 5'd0, c2);
    emit(core_pkg::op_mov, 5'd10, 5'd8, 5'd0, 12'h000);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    v3 = 64'(a) + 64'(b);
    v4 = v3 - 64'(a) - sext(c);
    v6 = ~(v4 ^ v3);
    finish_entry(5'd10, (((v6 << s1) >> s2) | 64'(a)) + sext(c2));
endtask

task automatic build_table();
    logic [11:0] hi;
    logic [11:0] lo;
    logic [63:0] stored;
    num_tests = 0;
    alu_entry("alu_chain_a");
    alu_entry("alu_chain_b");

    // store at 0x3008, load back through a negative offset, use at once
    hi     = 12'(rand_bits(12));
    lo     = 12'(rand_bits(12));
    stored = (64'(hi) << 40) | 64'(lo);
    start_entry("store_load");
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h300);
    emit(core_pkg::op_shli, 5'd1, 5'd1, 5'd0, 12'd4);
    emit(core_pkg::op_mov_l, 5'd2, 5'd0, 5'd0, hi);
    emit(core_pkg::op_shli, 5'd2, 5'd2, 5'd0, 12'd40);
    emit(core_pkg::op_mov_l, 5'd2, 5'd0, 5'd0, lo);
    emit(core_pkg::op_store, 5'd1, 5'd2, 5'd0, 12'd8);
    emit(core_pkg::op_mov, 5'd5, 5'd1, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd5, 5'd0, 5'd0, 12'd16);
    emit(core_pkg::op_load, 5'd3, 5'd5, 5'd0, 12'hFF8);
    emit(core_pkg::op_add, 5'd4, 5'd3, 5'd3, 12'h000);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    finish_entry(5'd4, stored + stored);

    // every taken branch skips an addi of 0x100
    start_entry("taken_branches");
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h200);
    emit(core_pkg::op_shli, 5'd1, 5'd1, 5'd0, 12'd4);
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h014);
    emit(core_pkg::op_jmp, 5'd1, 5'd0, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd1);
    emit(core_pkg::op_mov_l, 5'd2, 5'd0, 5'd0, 12'd12);
    // pc + 12, three words on
    emit(core_pkg::op_jmp_rr, 5'd2, 5'd0, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd2);
    emit(core_pkg::op_jmp_ri, 5'd0, 5'd0, 5'd0, 12'd8);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd4);
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h044);
    emit(core_pkg::op_brnz, 5'd1, 5'd10, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd8);
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h054);
    // 15 > 12 signed
    emit(core_pkg::op_brgt, 5'd1, 5'd10, 5'd2, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd16);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    finish_entry(5'd10, 64'd1 + 64'd2 + 64'd4 + 64'd8 + 64'd16);

    // wrong path lands on word 10
    start_entry("untaken_branches");
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h200);
    emit(core_pkg::op_shli, 5'd1, 5'd1, 5'd0, 12'd4);
    emit(core_pkg::op_mov_l, 5'd1, 5'd0, 5'd0, 12'h028);
    emit(core_pkg::op_brnz, 5'd1, 5'd0, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd3);
    emit(core_pkg::op_subi, 5'd2, 5'd0, 5'd0, 12'd5);
    // -5 > 3 only if compared unsigned
    emit(core_pkg::op_brgt, 5'd1, 5'd2, 5'd10, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h030);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h200);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h400);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    finish_entry(5'd10, 64'd3 + 64'h30 + 64'h200);

    // words behind the first halt never retire
    start_entry("halt_stops");
    emit(core_pkg::op_mov_l, 5'd10, 5'd0, 5'd0, 12'h123);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'd1);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    emit(core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h100);
    emit(core_pkg::op_mov_l, 5'd10, 5'd0, 5'd0, 12'hFFF);
    emit(core_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'h000);
    finish_entry(5'd10, 64'h123 + 64'd1);
endtask

`endif

// ==== dv/core_tb.sv ====
module core_tb;

    localparam int          clk_period     = 10;
    localparam int          reset_cycles   = 5;
    localparam int          timeout_cycles = 2000;
    localparam logic [15:0] lfsr_seed      = 16'd91;
    localparam logic [63:0] prog_base      = 64'h2000;

    logic        clk;
    logic        reset;
    logic        run;
    logic        load_en;
    logic [63:0] load_addr;
    logic [31:0] load_word;
    logic [4:0]  dbg_reg_addr;
    logic [63:0] dbg_reg_data;
    logic        hlt;

    logic [15:0] lfsr;
    int          pass_count;
    int          fail_count;

    // 16-bit Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken, msb first
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // L as the core widens it
    function automatic logic [63:0] sext(input logic [11:0] l);
        return {{52{l[11]}}, l};
    endfunction

    `include "core_tb_programs.svh"

    core_top #(
        .mem_bytes (16384),
        .start_pc  (prog_base)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_word    (load_word),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .hlt          (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // reset pulse, returns 1 unit after a rising edge
    task automatic reset_core();
        @(posedge clk);
        #1;
        reset   = 1'b1;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // one word per cycle through the load port
    task automatic load_program(input int t);
        for (int i = 0; i < word_count[t]; i++) begin
            load_en   = 1'b1;
            load_addr = prog_base + 64'(4 * i);
            load_word = prog_words[first_word[t] + i];
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
    endtask

    // sampled on falling edges, away from the update
    task automatic wait_for_halt(output bit done);
        int cycles;
        cycles = 0;
        while (!hlt && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        done = hlt;
    endtask

    task automatic run_test(input int t);
        bit done;
        bit ok;
        ok = 1'b1;
        reset_core();
        if (hlt) begin
            $display("hlt is still high after reset in test %s", test_name[t]);
            ok = 1'b0;
        end
        load_program(t);
        run          = 1'b1;
        dbg_reg_addr = result_reg[t];
        wait_for_halt(done);
        if (!done) begin
            $display("Test %s timed out, hlt did not rise within %0d cycles",
                     test_name[t], timeout_cycles);
            ok = 1'b0;
        end else if (dbg_reg_data !== expected[t]) begin
            $display("Mismatch in test %s: expected %h, actual %h",
                     test_name[t], expected[t], dbg_reg_data);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("test %s ok, r%0d = %h", test_name[t], result_reg[t], dbg_reg_data);
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        run          = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_word    = '0;
        dbg_reg_addr = '0;
        lfsr         = lfsr_seed;
        pass_count   = 0;
        fail_count   = 0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 num_tests, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+dv
verilog/core_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pipe_control.sv
verilog/execute_stage.sv
verilog/core_memory.sv
verilog/core_top.sv
dv/core_tb.sv
